/* src/ex_pkg.sv */
package ex_pkg;

    localparam int xlen = 64;

    typedef logic [xlen-1:0] word_t;

    // The signed forms report overflow; the unsigned forms never do.
    typedef enum logic [2:0] {
        alu_add,
        alu_addu,
        alu_sub,
        alu_subu,
        alu_and,
        alu_or,
        alu_xor,
        alu_nor
    } alu_op_t;

    typedef enum logic [1:0] {
        fwd_reg,
        fwd_ex,
        fwd_mem
    } fwd_sel_t;

    typedef enum logic [1:0] {
        a_fwd,
        a_shift,
        a_pc
    } a_src_t;

    typedef enum logic [1:0] {
        b_fwd,
        b_shift,
        b_sext_imm,
        b_zext_imm
    } b_src_t;

    typedef enum logic [1:0] {
        res_alu,
        res_shift,
        res_branch
    } result_src_t;

    typedef enum logic [1:0] {
        cut_full,
        cut_sext32,
        cut_zext32
    } alu_cut_t;

    typedef enum logic [1:0] {
        scut_shift,
        scut_rotate,
        scut_shift32,
        scut_rotate32
    } shift_cut_t;

    // Word moves used by the dsll32/dsrl32 style instructions.
    typedef enum logic [1:0] {
        p32_none,
        p32_lo_to_hi,
        p32_hi_to_lo,
        p32_swap
    } plus32_t;

    typedef enum logic [1:0] {
        slt_none,
        slt_signed,
        slt_unsigned
    } slt_t;

    typedef enum logic [1:0] {
        ext_none,
        ext_byte,
        ext_half
    } ext_t;

    // Control bits that the execute stage only carries to memory and writeback.
    typedef struct packed {
        logic [2:0] load_type;
        logic [1:0] store_type;
        logic       signed_mem_out;
        logic       write_enable;
        logic       beq;
        logic       bne;
        logic       bc;
        logic       bal;
        logic       linkpc;
        logic       mfc0;
        logic       mtc0;
        logic       syscall;
        logic       break_;
        logic [4:0] cp0_rd;
    } mem_ctrl_t;

    typedef struct packed {
        word_t       pc;
        word_t       pc4;
        word_t       pc_branch;
        word_t       a_data;
        word_t       b_data;
        logic [31:0] inst;
        logic [4:0]  w_regnum;
        logic [5:0]  shamt;
        alu_op_t     alu_op;
        a_src_t      alu_a_src;
        b_src_t      alu_b_src;
        result_src_t ex_out_src;
        alu_cut_t    cut_alu;
        shift_cut_t  cut_shift;
        plus32_t     plus32;
        slt_t        slt_type;
        ext_t        ext_src;
        logic        barrel_src;
        logic        barrel_right;
        logic        shift_arith;
        logic        lui;
        logic        ignore_overflow;
        mem_ctrl_t   ctrl;
    } id_regs_t;

    typedef struct packed {
        word_t      out;
        word_t      b_data;
        logic [4:0] w_regnum;
        word_t      pc4;
        word_t      pc_branch;
        logic       overflow;
        logic       zero;
        logic [2:0] sel;
        mem_ctrl_t  ctrl;
    } ex_regs_t;

    typedef struct packed {
        logic overflow;
        logic zero;
        logic negative;
        logic borrow;
    } alu_flags_t;

endpackage

/* src/ex_operand_select.sv */
`timescale 1ns/1ps

module ex_operand_select (
    input  ex_pkg::id_regs_t id_regs,
    input  ex_pkg::word_t    ex_out,
    input  ex_pkg::word_t    mem_data,
    input  ex_pkg::fwd_sel_t forward_a,
    input  ex_pkg::fwd_sel_t forward_b,
    input  ex_pkg::word_t    shift_result,
    output ex_pkg::word_t    fwd_a,
    output ex_pkg::word_t    fwd_b,
    output ex_pkg::word_t    alu_a,
    output ex_pkg::word_t    alu_b,
    output ex_pkg::word_t    shift_in
);
    import ex_pkg::*;

    word_t sext_imm;
    word_t zext_imm;

    // The hazard unit decides where each operand comes from.
    always_comb begin
        case (forward_a)
            fwd_ex:  fwd_a = ex_out;
            fwd_mem: fwd_a = mem_data;
            default: fwd_a = id_regs.a_data;
        endcase
    end

    always_comb begin
        case (forward_b)
            fwd_ex:  fwd_b = ex_out;
            fwd_mem: fwd_b = mem_data;
            default: fwd_b = id_regs.b_data;
        endcase
    end

    assign sext_imm = {{48{id_regs.inst[15]}}, id_regs.inst[15:0]};
    assign zext_imm = {48'b0, id_regs.inst[15:0]};

    // A shifted value may feed either adder input, e.g. for scaled address math.
    always_comb begin
        case (id_regs.alu_a_src)
            a_shift: alu_a = shift_result;
            a_pc:    alu_a = id_regs.pc;
            default: alu_a = fwd_a;
        endcase
    end

    always_comb begin
        case (id_regs.alu_b_src)
            b_shift:    alu_b = shift_result;
            b_sext_imm: alu_b = sext_imm;
            b_zext_imm: alu_b = zext_imm;
            default:    alu_b = fwd_b;
        endcase
    end

    assign shift_in = id_regs.barrel_src ? fwd_a : fwd_b;

    // The 2-bit forwarding and A source selects each leave one encoding unused.
    always_comb begin
        assert final ($isunknown({forward_a, forward_b, id_regs.alu_a_src})
                      || (forward_a inside {fwd_reg, fwd_ex, fwd_mem}
                          && forward_b inside {fwd_reg, fwd_ex, fwd_mem}
                          && id_regs.alu_a_src inside {a_fwd, a_shift, a_pc}))
        else $error("undefined operand select encoding");
    end

endmodule

/* src/ex_alu.sv */
`timescale 1ns/1ps

module ex_alu (
    input  ex_pkg::word_t      a,
    input  ex_pkg::word_t      b,
    input  ex_pkg::alu_op_t    op,
    input  ex_pkg::alu_cut_t   cut,
    output ex_pkg::word_t      result,
    output ex_pkg::alu_flags_t flags
);
    import ex_pkg::*;

    word_t         sum;
    word_t         diff;
    logic          borrow;
    logic          add_ovf;
    logic          sub_ovf;
    word_t         raw;
    logic [xlen:0] wide_sum;
    logic [xlen:0] wide_diff;

    assign sum = a + b;

    // The extra top bit of the subtraction is the unsigned borrow.
    assign {borrow, diff} = {1'b0, a} - {1'b0, b};

    assign add_ovf = (a[xlen-1] == b[xlen-1]) && (sum[xlen-1] != a[xlen-1]);
    assign sub_ovf = (a[xlen-1] != b[xlen-1]) && (diff[xlen-1] != a[xlen-1]);

    // Sign-extended 65-bit forms of the sum and difference.
    assign wide_sum = {a[xlen-1], a} + {b[xlen-1], b};
    assign wide_diff = {a[xlen-1], a} - {b[xlen-1], b};

    always_comb begin
        raw = sum;
        flags.overflow = 1'b0;
        case (op)
            alu_add: begin
                raw = sum;
                flags.overflow = add_ovf;
            end
            alu_addu: raw = sum;
            alu_sub: begin
                raw = diff;
                flags.overflow = sub_ovf;
            end
            alu_subu: raw = diff;
            alu_and:  raw = a & b;
            alu_or:   raw = a | b;
            alu_xor:  raw = a ^ b;
            alu_nor:  raw = ~(a | b);
            default:  raw = sum;
        endcase
        // Flags see the full 64-bit result, not the cut one.
        flags.zero = (raw == '0);
        flags.negative = diff[xlen-1];
        flags.borrow = borrow;
    end

    always_comb begin
        case (cut)
            cut_sext32: result = {{32{raw[31]}}, raw[31:0]};
            cut_zext32: result = {32'b0, raw[31:0]};
            default:    result = raw;
        endcase
    end

    // Only the signed forms overflow, exactly when the 65-bit result leaves the 64-bit range.
    always_comb begin
        assert final ($isunknown({a, b, op})
                      || flags.overflow == ((op == alu_add && wide_sum[xlen] != wide_sum[xlen-1])
                          || (op == alu_sub && wide_diff[xlen] != wide_diff[xlen-1])))
        else $error("overflow flag disagrees with the 65-bit result");
    end

endmodule

/* src/ex_shift_unit.sv */
`timescale 1ns/1ps

module ex_shift_unit (
    input  ex_pkg::word_t      data,
    input  logic [5:0]         shamt,
    input  logic               right,
    input  logic               arith,
    input  ex_pkg::shift_cut_t cut,
    input  ex_pkg::plus32_t    plus32,
    output ex_pkg::word_t      result
);
    import ex_pkg::*;

    logic [6:0] back_amt;
    word_t      shifted;
    word_t      rotated;
    word_t      cut_out;

    // A shift by 64 clears the word, which covers the shamt of zero case.
    assign back_amt = 7'd64 - {1'b0, shamt};

    always_comb begin
        if (right) begin
            if (arith) begin
                shifted = word_t'($signed(data) >>> shamt);
            end else begin
                shifted = data >> shamt;
            end
        end else begin
            shifted = data << shamt;
        end
    end

    always_comb begin
        if (right) begin
            rotated = (data >> shamt) | (data << back_amt);
        end else begin
            rotated = (data << shamt) | (data >> back_amt);
        end
    end

    // The 32-bit forms keep the low word of the 64-bit operation.
    always_comb begin
        case (cut)
            scut_rotate:   cut_out = rotated;
            scut_shift32:  cut_out = {{32{shifted[31]}}, shifted[31:0]};
            scut_rotate32: cut_out = {{32{rotated[31]}}, rotated[31:0]};
            default:       cut_out = shifted;
        endcase
    end

    always_comb begin
        case (plus32)
            p32_lo_to_hi: result = {cut_out[31:0], 32'b0};
            p32_hi_to_lo: result = {32'b0, cut_out[63:32]};
            p32_swap:     result = {cut_out[31:0], cut_out[63:32]};
            default:      result = cut_out;
        endcase
    end

endmodule

/* src/core_ex.sv */
`timescale 1ns/1ps

module core_ex (
    input  logic             clock,
    input  logic             reset,
    input  ex_pkg::id_regs_t id_regs,
    input  logic             flush,
    input  ex_pkg::word_t    mem_data,
    input  ex_pkg::fwd_sel_t forward_a,
    input  ex_pkg::fwd_sel_t forward_b,
    input  logic             take_handler,
    output ex_pkg::ex_regs_t ex_regs
);
    import ex_pkg::*;

    word_t      fwd_a;
    word_t      fwd_b;
    word_t      alu_a;
    word_t      alu_b;
    word_t      shift_in;
    word_t      shift_result;
    word_t      alu_result;
    alu_flags_t flags;
    word_t      sel_out;
    word_t      lui_out;
    word_t      slt_out;
    word_t      ext_out;
    logic       signed_lt;
    logic       kill;
    ex_regs_t   ex_next;

    ex_operand_select u_operand_select (
        .id_regs     (id_regs),
        .ex_out      (ex_regs.out),
        .mem_data    (mem_data),
        .forward_a   (forward_a),
        .forward_b   (forward_b),
        .shift_result(shift_result),
        .fwd_a       (fwd_a),
        .fwd_b       (fwd_b),
        .alu_a       (alu_a),
        .alu_b       (alu_b),
        .shift_in    (shift_in)
    );

    ex_shift_unit u_shift_unit (
        .data  (shift_in),
        .shamt (id_regs.shamt),
        .right (id_regs.barrel_right),
        .arith (id_regs.shift_arith),
        .cut   (id_regs.cut_shift),
        .plus32(id_regs.plus32),
        .result(shift_result)
    );

    ex_alu u_alu (
        .a     (alu_a),
        .b     (alu_b),
        .op    (id_regs.alu_op),
        .cut   (id_regs.cut_alu),
        .result(alu_result),
        .flags (flags)
    );

    always_comb begin
        case (id_regs.ex_out_src)
            res_shift:  sel_out = shift_result;
            res_branch: sel_out = id_regs.pc_branch;
            default:    sel_out = alu_result;
        endcase
    end

    assign lui_out = id_regs.lui ? {{32{id_regs.inst[15]}}, id_regs.inst[15:0], 16'b0}
                                 : sel_out;

    // With differing signs A is smaller exactly when it is negative.
    assign signed_lt = (fwd_a[xlen-1] != fwd_b[xlen-1]) ? fwd_a[xlen-1] : flags.negative;

    always_comb begin
        case (id_regs.slt_type)
            slt_signed:   slt_out = {63'b0, signed_lt};
            slt_unsigned: slt_out = {63'b0, flags.borrow};
            default:      slt_out = lui_out;
        endcase
    end

    // seb and seh read the register value as decoded, without forwarding.
    always_comb begin
        case (id_regs.ext_src)
            ext_byte: ext_out = {{56{id_regs.b_data[7]}}, id_regs.b_data[7:0]};
            ext_half: ext_out = {{48{id_regs.b_data[15]}}, id_regs.b_data[15:0]};
            default:  ext_out = slt_out;
        endcase
    end

    always_comb begin
        ex_next.out = ext_out;
        ex_next.b_data = fwd_b;
        ex_next.w_regnum = id_regs.w_regnum;
        ex_next.pc4 = id_regs.pc4;
        ex_next.pc_branch = id_regs.pc_branch;
        ex_next.overflow = flags.overflow && !id_regs.ignore_overflow;
        ex_next.zero = flags.zero;
        ex_next.sel = id_regs.inst[2:0];
        ex_next.ctrl = id_regs.ctrl;
    end

    // A link instruction survives a flush unless an exception handler is entered.
    assign kill = flush && (!id_regs.ctrl.linkpc || take_handler);

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ex_regs <= '0;
        end else if (kill) begin
            ex_regs <= '0;
        end else begin
            ex_regs <= ex_next;
        end
    end

    assert property (@(posedge clock) disable iff (reset)
                     flush && !(id_regs.ctrl.linkpc && !take_handler) |=> ex_regs == '0)
    else $error("execute register not cleared after flush");

endmodule

/* verif/tb_core_ex.sv */
`timescale 1ns/1ps

module tb_core_ex;
    import ex_pkg::*;

    localparam int max_cycles = 2000;

    logic     clock;
    logic     reset;
    id_regs_t id_regs;
    logic     flush;
    word_t    mem_data;
    fwd_sel_t forward_a;
    fwd_sel_t forward_b;
    logic     take_handler;
    ex_regs_t ex_regs;
    int       cycles;
    word_t    last_out;

    core_ex UUT (
        .clock       (clock),
        .reset       (reset),
        .id_regs     (id_regs),
        .flush       (flush),
        .mem_data    (mem_data),
        .forward_a   (forward_a),
        .forward_b   (forward_b),
        .take_handler(take_handler),
        .ex_regs     (ex_regs)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge clock);
            cycles++;
            if (cycles >= max_cycles) begin
                $display("Run did not finish within %0d clock cycles", max_cycles);
                abort_run();
            end
        end
    end

    task automatic abort_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flags(input string name, input alu_flags_t exp, input alu_flags_t act);
        if (exp.overflow !== act.overflow || exp.zero !== act.zero) begin
            $display("[FAIL] %0t %s expected ovf=%b zero=%b got ovf=%b zero=%b", $time, name,
                     exp.overflow, exp.zero, act.overflow, act.zero);
            abort_run();
        end
    endtask

    task automatic check_ctrl(input string name, input mem_ctrl_t exp, input mem_ctrl_t act);
        if (exp !== act) begin
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp, act);
            abort_run();
        end
    endtask

    function automatic word_t rand_word();
        return {$urandom, $urandom};
    endfunction

    function automatic id_regs_t rand_id();
        id_regs_t    d;
        logic [31:0] r;
        d = '0;
        d.pc = rand_word();
        d.pc4 = rand_word();
        d.pc_branch = rand_word();
        d.a_data = rand_word();
        d.b_data = rand_word();
        d.inst = $urandom;
        r = $urandom;
        d.w_regnum = r[4:0];
        d.shamt = r[10:5];
        r = $urandom;
        d.ctrl = r[$bits(mem_ctrl_t)-1:0];
        return d;
    endfunction

    // Expected execute register for one instruction, built from the stage rules.
    function automatic ex_regs_t model(input id_regs_t d, input fwd_sel_t fa, input fwd_sel_t fb,
                                       input word_t ex_prev, input word_t mem);
        word_t        a;
        word_t        b;
        word_t        sh_in;
        word_t        s;
        word_t        rot;
        word_t        sh;
        word_t        x;
        word_t        y;
        word_t        raw;
        word_t        res;
        logic [127:0] dbl;
        logic [64:0]  wide;
        logic         ovf;
        ex_regs_t     e;
        a = (fa == fwd_ex) ? ex_prev : (fa == fwd_mem) ? mem : d.a_data;
        b = (fb == fwd_ex) ? ex_prev : (fb == fwd_mem) ? mem : d.b_data;
        sh_in = d.barrel_src ? a : b;
        if (!d.barrel_right) s = sh_in << d.shamt;
        else if (d.shift_arith) s = $signed(sh_in) >>> d.shamt;
        else s = sh_in >> d.shamt;
        // Rotation is read out of the word placed twice side by side.
        dbl = {sh_in, sh_in};
        if (d.barrel_right) begin
            dbl = dbl >> d.shamt;
            rot = dbl[63:0];
        end else begin
            dbl = dbl << d.shamt;
            rot = dbl[127:64];
        end
        case (d.cut_shift)
            scut_rotate:   sh = rot;
            scut_shift32:  sh = {{32{s[31]}}, s[31:0]};
            scut_rotate32: sh = {{32{rot[31]}}, rot[31:0]};
            default:       sh = s;
        endcase
        case (d.plus32)
            p32_lo_to_hi: sh = {sh[31:0], 32'h0};
            p32_hi_to_lo: sh = {32'h0, sh[63:32]};
            p32_swap:     sh = {sh[31:0], sh[63:32]};
            default:      sh = sh;
        endcase
        x = (d.alu_a_src == a_shift) ? sh : (d.alu_a_src == a_pc) ? d.pc : a;
        case (d.alu_b_src)
            b_shift:    y = sh;
            b_sext_imm: y = {{48{d.inst[15]}}, d.inst[15:0]};
            b_zext_imm: y = {48'h0, d.inst[15:0]};
            default:    y = b;
        endcase
        ovf = 1'b0;
        case (d.alu_op)
            alu_add, alu_addu: begin
                raw = x + y;
                wide = {x[63], x} + {y[63], y};
                ovf = (d.alu_op == alu_add) && (wide[64] != wide[63]);
            end
            alu_sub, alu_subu: begin
                raw = x - y;
                wide = {x[63], x} - {y[63], y};
                ovf = (d.alu_op == alu_sub) && (wide[64] != wide[63]);
            end
            alu_and: raw = x & y;
            alu_or:  raw = x | y;
            alu_xor: raw = x ^ y;
            default: raw = ~(x | y);
        endcase
        e = '0;
        e.zero = (raw == 64'h0);
        e.overflow = ovf && !d.ignore_overflow;
        if (d.cut_alu == cut_sext32) raw = {{32{raw[31]}}, raw[31:0]};
        else if (d.cut_alu == cut_zext32) raw = {32'h0, raw[31:0]};
        res = (d.ex_out_src == res_shift) ? sh : (d.ex_out_src == res_branch) ? d.pc_branch : raw;
        if (d.lui) res = {{48{d.inst[15]}}, d.inst[15:0]} << 16;
        if (d.slt_type == slt_signed) res = {63'h0, $signed(a) < $signed(b)};
        if (d.slt_type == slt_unsigned) res = {63'h0, x < y};
        if (d.ext_src == ext_byte) res = {{56{d.b_data[7]}}, d.b_data[7:0]};
        if (d.ext_src == ext_half) res = {{48{d.b_data[15]}}, d.b_data[15:0]};
        e.out = res;
        e.b_data = b;
        e.w_regnum = d.w_regnum;
        e.pc4 = d.pc4;
        e.pc_branch = d.pc_branch;
        e.sel = d.inst[2:0];
        e.ctrl = d.ctrl;
        return e;
    endfunction

    task automatic expect_regs(input ex_regs_t exp);
        alu_flags_t ef;
        alu_flags_t af;
        ef = '0;
        af = '0;
        ef.overflow = exp.overflow;
        ef.zero = exp.zero;
        af.overflow = ex_regs.overflow;
        af.zero = ex_regs.zero;
        check_word("ex_regs.out", exp.out, ex_regs.out);
        check_word("ex_regs.b_data", exp.b_data, ex_regs.b_data);
        check_word("ex_regs.pc4", exp.pc4, ex_regs.pc4);
        check_word("ex_regs.pc_branch", exp.pc_branch, ex_regs.pc_branch);
        check_word("ex_regs.w_regnum", word_t'(exp.w_regnum), word_t'(ex_regs.w_regnum));
        check_word("ex_regs.sel", word_t'(exp.sel), word_t'(ex_regs.sel));
        check_flags("ex_regs flags", ef, af);
        check_ctrl("ex_regs.ctrl", exp.ctrl, ex_regs.ctrl);
    endtask

    // Called on a falling edge; returns on the falling edge after the capture.
    task automatic step(input id_regs_t d, input fwd_sel_t fa, input fwd_sel_t fb,
                        input word_t mem, input logic fl, input logic th);
        ex_regs_t exp;
        id_regs = d;
        forward_a = fa;
        forward_b = fb;
        mem_data = mem;
        flush = fl;
        take_handler = th;
        if (fl && !(d.ctrl.linkpc && !th)) exp = '0;
        else exp = model(d, fa, fb, last_out, mem);
        @(posedge clock);
        @(negedge clock);
        expect_regs(exp);
        last_out = exp.out;
        flush = 1'b0;
        take_handler = 1'b0;
    endtask

    task automatic issue(input id_regs_t d);
        step(d, fwd_reg, fwd_reg, rand_word(), 1'b0, 1'b0);
    endtask

    task automatic reset_and_flush();
        id_regs_t d;
        expect_regs('0);
        d = rand_id();
        d.ctrl.linkpc = 1'b0;
        step(d, fwd_reg, fwd_reg, rand_word(), 1'b1, 1'b0);
        d = rand_id();
        d.ctrl.linkpc = 1'b1;
        step(d, fwd_reg, fwd_reg, rand_word(), 1'b1, 1'b0);
        step(d, fwd_reg, fwd_reg, rand_word(), 1'b1, 1'b1);
    endtask

    task automatic alu_ops();
        id_regs_t d;
        for (int op = 0; op < 8; op++) begin
            for (int c = 0; c < 3; c++) begin
                d = rand_id();
                d.alu_op = alu_op_t'(op);
                d.cut_alu = alu_cut_t'(c);
                d.ignore_overflow = 1'($urandom);
                issue(d);
            end
        end
        d = rand_id();
        d.a_data = 64'h7fff_ffff_ffff_ffff;
        d.b_data = 64'h1;
        issue(d);
        d.ignore_overflow = 1'b1;
        issue(d);
        d.alu_op = alu_sub;
        d.b_data = d.a_data;
        issue(d);
        d.ignore_overflow = 1'b0;
        d.b_data = '1;
        issue(d);
        for (int i = 0; i < 4; i++) begin
            d = rand_id();
            d.inst[15] = i[0];
            d.alu_b_src = i[1] ? b_zext_imm : b_sext_imm;
            issue(d);
        end
    endtask

    task automatic shift_ops();
        id_regs_t    d;
        logic [31:0] r;
        for (int i = 0; i < 32; i++) begin
            d = rand_id();
            r = $urandom;
            d.ex_out_src = res_shift;
            d.cut_shift = shift_cut_t'(i[1:0]);
            d.plus32 = plus32_t'(i[3:2]);
            d.barrel_right = i[4];
            d.shift_arith = i[2];
            d.barrel_src = r[1];
            issue(d);
        end
        for (int i = 0; i < 4; i++) begin
            d = rand_id();
            d.alu_op = alu_op_t'(i);
            if (i[0]) d.alu_b_src = b_shift;
            else d.alu_a_src = a_shift;
            issue(d);
        end
    endtask

    task automatic forwarding();
        issue(rand_id());
        step(rand_id(), fwd_ex, fwd_reg, rand_word(), 1'b0, 1'b0);
        step(rand_id(), fwd_reg, fwd_ex, rand_word(), 1'b0, 1'b0);
        step(rand_id(), fwd_mem, fwd_reg, rand_word(), 1'b0, 1'b0);
        step(rand_id(), fwd_reg, fwd_mem, rand_word(), 1'b0, 1'b0);
    endtask

    task automatic compare_and_extend();
        id_regs_t d;
        for (int i = 0; i < 8; i++) begin
            d = rand_id();
            d.alu_op = alu_sub;
            d.slt_type = i[0] ? slt_unsigned : slt_signed;
            d.b_data[63] = i[1] ? d.a_data[63] : ~d.a_data[63];
            issue(d);
        end
        d = rand_id();
        d.lui = 1'b1;
        issue(d);
        d = rand_id();
        d.ext_src = ext_byte;
        issue(d);
        // The extension reads the decoded B even while B is forwarded.
        d.ext_src = ext_half;
        step(d, fwd_reg, fwd_mem, rand_word(), 1'b0, 1'b0);
        d = rand_id();
        d.ex_out_src = res_branch;
        issue(d);
    endtask

    initial begin
        void'($urandom(32'h5ce5));
        reset = 1'b1;
        flush = 1'b0;
        take_handler = 1'b0;
        id_regs = '0;
        mem_data = '0;
        forward_a = fwd_reg;
        forward_b = fwd_reg;
        last_out = '0;
        repeat (10) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        reset_and_flush();
        alu_ops();
        shift_ops();
        forwarding();
        compare_and_extend();
        for (int i = 0; i < 16; i++) begin
            issue(rand_id());
        end
        $display("No errors");
        $finish;
    end

endmodule

/* filelist.f */
src/ex_pkg.sv
src/ex_operand_select.sv
src/ex_alu.sv
src/ex_shift_unit.sv
src/core_ex.sv
verif/tb_core_ex.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_core_ex
FILELIST  = filelist.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); echo "$$out"; echo "$$out" | grep -qx 'No errors'

clean:
	rm -rf $(OBJ_DIR)
